// ==== logic/rv_isa_pkg.sv ====
// RV64I instruction encodings: opcodes, funct3 and funct7 codes, field types
package rv_isa_pkg;

    typedef logic [31:0] instr_t;               // Raw instruction word
    typedef logic [6:0]  opcode_t;              // Major opcode, bits 6:0
    typedef logic [2:0]  funct3_t;              // Minor function, bits 14:12

    // Major opcodes handled by the core
    localparam opcode_t OP_LUI      = 7'b0110111;
    localparam opcode_t OP_AUIPC    = 7'b0010111;
    localparam opcode_t OP_JAL      = 7'b1101111;
    localparam opcode_t OP_JALR     = 7'b1100111;
    localparam opcode_t OP_BRANCH   = 7'b1100011;
    localparam opcode_t OP_STORE    = 7'b0100011;
    localparam opcode_t OP_OP_IMM   = 7'b0010011;
    localparam opcode_t OP_OP_IMM_W = 7'b0011011;
    localparam opcode_t OP_OP       = 7'b0110011;
    localparam opcode_t OP_OP_W     = 7'b0111011;
    localparam opcode_t OP_FENCE    = 7'b0001111; // FENCE and FENCE.I

    // Integer ALU functions
    localparam funct3_t F3_ADD  = 3'b000;       // Add, sub
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;       // Srl, sra
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // Branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // Sub and arithmetic right shift
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // addi x0,x0,0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== logic/rv_core_pkg.sv ====
// Core datapath types: register word, register index, store size and PC step
package rv_core_pkg;

    localparam int XLEN = 64;                   // RV64

    typedef logic [XLEN-1:0] word_t;            // Register or memory word
    typedef logic [4:0]      reg_idx_t;         // x0..x31
    typedef logic [1:0]      mem_size_t;        // Store width, funct3[1:0]

    // Store widths as encoded in funct3
    localparam mem_size_t SIZE_B = 2'd0;        // Byte
    localparam mem_size_t SIZE_H = 2'd1;        // Half word
    localparam mem_size_t SIZE_W = 2'd2;        // Word
    localparam mem_size_t SIZE_D = 2'd3;        // Double word

    // Sequential PC step, one 32-bit instruction
    localparam word_t INSTR_BYTES = 64'd4;

endpackage

// ==== logic/reg_file.sv ====
// Integer register file, 2 async reads, 1 sync write, x0 hard-wired to zero
`timescale 1ns/10ps

module reg_file (
    input  logic                  clk_1hz,
    input  logic                  reset_n,
    input  rv_core_pkg::reg_idx_t rs1,
    input  rv_core_pkg::reg_idx_t rs2,
    output rv_core_pkg::word_t    rs1_val,
    output rv_core_pkg::word_t    rs2_val,
    input  rv_core_pkg::reg_idx_t rd,
    input  logic                  rd_we,
    input  rv_core_pkg::word_t    rd_data
);
    import rv_core_pkg::*;

    word_t regs [1:31];                         // x1..x31 only

    // Write port, x0 writes dropped
    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;                  // Clear whole file
            end
        end else if (rd_we && (rd != '0)) begin
            regs[rd] <= rd_data;
        end
    end

    // Read ports, index 0 reads zero
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== logic/fetch_unit.sv ====
// Fetch stage: PC, instruction register and one-slot bubble on redirect
`timescale 1ns/10ps

module fetch_unit #(
    parameter rv_core_pkg::word_t RESET_PC = '0
) (
    input  logic                clk_1hz,
    input  logic                reset_n,
    output rv_core_pkg::word_t  imem_addr,
    input  rv_isa_pkg::instr_t  imem_data,
    input  logic                redirect,
    input  rv_core_pkg::word_t  redirect_pc,
    output rv_isa_pkg::instr_t  instr,
    output rv_core_pkg::word_t  instr_pc,
    output logic                instr_valid
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    word_t pc;                                  // Address being fetched

    assign imem_addr = pc;                      // Memory answers in same cycle

    // PC and instruction register
    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            pc          <= RESET_PC;
            instr       <= NOP_INSTR;
            instr_valid <= 1'b0;
        end else begin
            instr <= imem_data;                 // Latch returned word
            if (redirect) begin
                pc          <= redirect_pc;     // Jump or taken branch
                instr_valid <= 1'b0;            // Word fetched alongside is dead
            end else begin
                pc          <= pc + INSTR_BYTES;
                instr_valid <= 1'b1;
            end
        end
    end

    // PC of the word now in instr
    always_ff @(posedge clk_1hz) begin
        instr_pc <= pc;
    end

endmodule

// ==== logic/int_alu.sv ====
// Integer ALU: destination value for arithmetic, word, upper-immediate and link ops
`timescale 1ns/10ps

module int_alu (
    input  rv_isa_pkg::instr_t instr,
    input  rv_core_pkg::word_t instr_pc,
    input  rv_core_pkg::word_t rs1_val,
    input  rv_core_pkg::word_t rs2_val,
    output rv_core_pkg::word_t alu_result,
    output logic               writes_rd
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    opcode_t     opcode;
    funct3_t     f3;
    word_t       imm_i;                         // addi, shifts, addiw
    word_t       imm_u;                         // lui, auipc
    word_t       op_b;                          // Second operand
    logic        is_reg;                        // Register-register form
    logic        sub_sel;
    logic        sra_sel;
    logic [5:0]  shamt64;
    logic [4:0]  shamt32;
    word_t       res64;
    logic [31:0] res32;

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign imm_i  = {{52{instr[31]}}, instr[31:20]};
    assign imm_u  = {{32{instr[31]}}, instr[31:12], 12'b0};

    assign is_reg  = (opcode == OP_OP) || (opcode == OP_OP_W);
    assign op_b    = is_reg ? rs2_val : imm_i;
    assign sub_sel = is_reg && (instr[31:25] == F7_ALT); // No subi
    assign sra_sel = instr[30];                 // Same bit in all four shift forms
    assign shamt64 = op_b[5:0];                 // imm_i[5:0] is instr[25:20]
    assign shamt32 = op_b[4:0];

    // 64-bit result
    always_comb begin
        case (f3)
            F3_ADD:  res64 = sub_sel ? rs1_val - op_b : rs1_val + op_b;
            F3_SLL:  res64 = rs1_val << shamt64;
            F3_SLT:  res64 = {{(XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
            F3_SLTU: res64 = {{(XLEN-1){1'b0}}, rs1_val < op_b};
            F3_XOR:  res64 = rs1_val ^ op_b;
            F3_OR:   res64 = rs1_val | op_b;
            F3_AND:  res64 = rs1_val & op_b;
            default: begin                      // F3_SR
                if (sra_sel) begin
                    res64 = $signed(rs1_val) >>> shamt64;
                end else begin
                    res64 = rs1_val >> shamt64;
                end
            end
        endcase
    end

    // 32-bit result, low word of rs1 only
    always_comb begin
        case (f3)
            F3_ADD: res32 = sub_sel ? rs1_val[31:0] - op_b[31:0] : rs1_val[31:0] + op_b[31:0];
            F3_SLL: res32 = rs1_val[31:0] << shamt32;
            F3_SR: begin
                if (sra_sel) begin
                    res32 = $signed(rs1_val[31:0]) >>> shamt32;
                end else begin
                    res32 = rs1_val[31:0] >> shamt32; // Shift of 0 keeps bit 31 for sign-ext
                end
            end
            default: res32 = '0;                // No other word forms
        endcase
    end

    // Result select and writeback flag
    always_comb begin
        writes_rd  = 1'b1;
        alu_result = '0;
        case (opcode)
            OP_LUI:                alu_result = imm_u;
            OP_AUIPC:              alu_result = instr_pc + imm_u;
            OP_JAL, OP_JALR:       alu_result = instr_pc + INSTR_BYTES; // Link
            OP_OP, OP_OP_IMM:      alu_result = res64;
            OP_OP_W, OP_OP_IMM_W:  alu_result = {{32{res32[31]}}, res32};
            OP_BRANCH, OP_STORE, OP_FENCE: writes_rd = 1'b0;
            default:               writes_rd = 1'b0; // Unknown opcode ignored
        endcase
    end

endmodule

// ==== logic/flow_unit.sv ====
// Control flow: branch compare, jump detect and target address
`timescale 1ns/10ps

module flow_unit (
    input  rv_isa_pkg::instr_t instr,
    input  rv_core_pkg::word_t instr_pc,
    input  rv_core_pkg::word_t rs1_val,
    input  rv_core_pkg::word_t rs2_val,
    output logic               flow_taken,
    output rv_core_pkg::word_t flow_target
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    opcode_t opcode;
    funct3_t f3;
    word_t   imm_b;
    word_t   imm_j;
    word_t   imm_i;
    logic    cond;                              // Branch condition holds

    assign opcode = instr[6:0];
    assign f3     = instr[14:12];
    assign imm_b  = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j  = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_i  = {{52{instr[31]}}, instr[31:20]};

    always_comb begin
        case (f3)
            F3_BEQ:  cond = (rs1_val == rs2_val);
            F3_BNE:  cond = (rs1_val != rs2_val);
            F3_BLT:  cond = ($signed(rs1_val) <  $signed(rs2_val));
            F3_BGE:  cond = ($signed(rs1_val) >= $signed(rs2_val));
            F3_BLTU: cond = (rs1_val <  rs2_val);
            F3_BGEU: cond = (rs1_val >= rs2_val);
            default: cond = 1'b0;               // Reserved encodings
        endcase
    end

    // Jumps always taken, branches on cond
    assign flow_taken = (opcode == OP_JAL) || (opcode == OP_JALR) ||
                        ((opcode == OP_BRANCH) && cond);

    always_comb begin
        case (opcode)
            OP_JAL:  flow_target = instr_pc + imm_j;
            OP_JALR: flow_target = (rs1_val + imm_i) & ~word_t'(1); // Bit 0 cleared
            default: flow_target = instr_pc + imm_b;
        endcase
    end

endmodule

// ==== logic/commit_unit.sv ====
// Commit: gates results with valid, drives writeback, redirect and store port
`timescale 1ns/10ps

module commit_unit (
    input  logic                   clk_1hz,
    input  logic                   reset_n,
    input  rv_isa_pkg::instr_t     instr,
    input  logic                   instr_valid,
    input  rv_core_pkg::word_t     alu_result,
    input  logic                   writes_rd,
    input  logic                   flow_taken,
    input  rv_core_pkg::word_t     flow_target,
    input  rv_core_pkg::word_t     rs1_val,
    input  rv_core_pkg::word_t     rs2_val,
    output logic                   rd_we,
    output rv_core_pkg::word_t     rd_data,
    output logic                   redirect,
    output rv_core_pkg::word_t     redirect_pc,
    output logic                   mem_we,
    output rv_core_pkg::word_t     mem_addr,
    output rv_core_pkg::word_t     mem_data,
    output rv_core_pkg::mem_size_t mem_size
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    logic      is_store;
    logic      store_fire;
    word_t     imm_s;
    word_t     store_addr;
    word_t     store_data;                      // rs2 masked to width
    mem_size_t store_size;

    assign is_store   = (instr[6:0] == OP_STORE);
    assign imm_s      = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign store_addr = rs1_val + imm_s;
    assign store_size = instr[13:12];

    // Bubbles have no effect
    assign rd_we      = instr_valid && writes_rd;
    assign redirect   = instr_valid && flow_taken;
    assign store_fire = instr_valid && is_store;

    assign rd_data     = alu_result;
    assign redirect_pc = flow_target;           // Taken by fetch at end of cycle

    always_comb begin
        case (store_size)
            SIZE_B:  store_data = {56'b0, rs2_val[7:0]};
            SIZE_H:  store_data = {48'b0, rs2_val[15:0]};
            SIZE_W:  store_data = {32'b0, rs2_val[31:0]};
            default: store_data = rs2_val;      // SIZE_D
        endcase
    end

    // Store port, one-cycle write pulse
    always_ff @(posedge clk_1hz or negedge reset_n) begin
        if (!reset_n) begin
            mem_we   <= 1'b0;
            mem_addr <= '0;
            mem_data <= '0;
            mem_size <= SIZE_B;
        end else begin
            mem_we <= store_fire;
            if (store_fire) begin
                mem_addr <= store_addr;         // Held until next store
                mem_data <= store_data;
                mem_size <= store_size;
            end
        end
    end

endmodule

// ==== logic/rv_core.sv ====
// Two-stage RV64I core: fetch stage feeding a single execute/commit stage
`timescale 1ns/10ps

module rv_core #(
    parameter rv_core_pkg::word_t RESET_PC = '0
) (
    input  logic                   clk_1hz,
    input  logic                   reset_n,
    output rv_core_pkg::word_t     imem_addr,
    input  rv_isa_pkg::instr_t     imem_data,
    output logic                   mem_we,
    output rv_core_pkg::word_t     mem_addr,
    output rv_core_pkg::word_t     mem_data,
    output rv_core_pkg::mem_size_t mem_size
);
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    instr_t   instr;                            // Instruction in execute
    word_t    instr_pc;
    logic     instr_valid;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    rs1_val;
    word_t    rs2_val;
    word_t    alu_result;
    logic     writes_rd;
    logic     flow_taken;
    word_t    flow_target;
    logic     rd_we;
    word_t    rd_data;
    logic     redirect;
    word_t    redirect_pc;

    // Register fields
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk_1hz, .reset_n, .imem_addr, .imem_data,
        .redirect, .redirect_pc, .instr, .instr_pc, .instr_valid
    );

    reg_file u_regs (
        .clk_1hz, .reset_n, .rs1, .rs2, .rs1_val, .rs2_val,
        .rd, .rd_we, .rd_data
    );

    int_alu u_alu (
        .instr, .instr_pc, .rs1_val, .rs2_val, .alu_result, .writes_rd
    );

    flow_unit u_flow (
        .instr, .instr_pc, .rs1_val, .rs2_val, .flow_taken, .flow_target
    );

    commit_unit u_commit (
        .clk_1hz, .reset_n, .instr, .instr_valid,
        .alu_result, .writes_rd, .flow_taken, .flow_target,
        .rs1_val, .rs2_val, .rd_we, .rd_data, .redirect, .redirect_pc,
        .mem_we, .mem_addr, .mem_data, .mem_size
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
// Testbench clock and reset source: 100 ns clock, reset held low for 8 cycles
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_1hz,
    output logic reset_n
);
    initial begin
        clk_1hz = 1'b0;
        forever #50 clk_1hz = ~clk_1hz;         // 100 ns period
    end

    initial begin
        reset_n = 1'b0;
        repeat (8) @(posedge clk_1hz);
        reset_n <= 1'b1;                        // Released on a rising edge
    end

endmodule

// ==== bench/rv_core_tb.sv ====
// RV64I core testbench that builds a program, runs it and checks every store in order
`timescale 1ns/10ps

module rv_core_tb;
    import rv_core_pkg::*;
    import rv_isa_pkg::*;

    localparam word_t       RESET_PC   = 64'h0;
    localparam word_t       STORE_BASE = 64'h400;   // Held in x3
    localparam int          PROG_WORDS = 256;
    localparam int          WAIT_LIMIT = 200;       // Cycles per wait
    localparam logic [31:0] LFSR_SEED  = 32'hc9a9b664;

    logic      clk_1hz;
    logic      reset_n;
    word_t     imem_addr;
    instr_t    imem_data;
    logic      mem_we;
    word_t     mem_addr;
    word_t     mem_data;
    mem_size_t mem_size;

    instr_t    prog [0:PROG_WORDS-1];           // Program table
    int        prog_len;
    int        st_off;                          // Next store offset from x3
    logic [31:0] lfsr;
    word_t     exp_addr [$];                    // Expected store table
    word_t     exp_data [$];
    mem_size_t exp_size [$];
    funct3_t   br_list [0:5];

    tb_clock_gen u_clk (.clk_1hz, .reset_n);

    rv_core #(
        .RESET_PC (RESET_PC)
    ) dut (
        .clk_1hz, .reset_n, .imem_addr, .imem_data,
        .mem_we, .mem_addr, .mem_data, .mem_size
    );

    // Same-cycle instruction memory returning NOP off the table or off word alignment
    assign imem_data = (imem_addr[1:0] == 2'b00 && imem_addr[63:2] < 62'(prog_len)) ?
                       prog[imem_addr[9:2]] : NOP_INSTR;

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // Instruction encoders for each format
    function automatic instr_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
            input reg_idx_t rs1, input funct3_t f3, input reg_idx_t rd, input opcode_t op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic instr_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
            input funct3_t f3, input reg_idx_t rd, input opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
            input reg_idx_t rs1, input funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic instr_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
            input reg_idx_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic instr_t u_type(input logic [19:0] imm, input reg_idx_t rd,
            input opcode_t op);
        return {imm, rd, op};
    endfunction

    function automatic instr_t j_type(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // Branch outcome from the ISA definition
    function automatic logic branch_cond(input funct3_t f3, input word_t x, input word_t y);
        case (f3)
            F3_BEQ:  return x == y;
            F3_BNE:  return x != y;
            F3_BLT:  return $signed(x) < $signed(y);
            F3_BGE:  return $signed(x) >= $signed(y);
            F3_BLTU: return x < y;
            default: return x >= y;             // BGEU
        endcase
    endfunction

    task fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task check_word(input string name, input word_t got, input word_t exp_val);
        if (got !== exp_val) begin
            fail_run($sformatf("CHECK FAILED t=%0t %s got %h expected %h",
                               $time, name, got, exp_val));
        end
    endtask

    task check_size(input string name, input mem_size_t got, input mem_size_t exp_val);
        if (got !== exp_val) begin
            fail_run($sformatf("CHECK FAILED t=%0t %s got %0d expected %0d",
                               $time, name, got, exp_val));
        end
    endtask

    task check_bit(input string name, input logic got, input logic exp_val);
        if (got !== exp_val) begin
            fail_run($sformatf("CHECK FAILED t=%0t %s got %b expected %b",
                               $time, name, got, exp_val));
        end
    endtask

    task emit(input instr_t ins);
        prog[prog_len] = ins;
        prog_len++;
    endtask

    // Store from rs at the next slot and its expected entry when it retires
    task put_store(input reg_idx_t rs, input mem_size_t size, input logic appears,
            input word_t data);
        emit(s_type(12'(st_off), rs, 5'd3, {1'b0, size}));
        if (appears) begin
            exp_addr.push_back(STORE_BASE + word_t'(st_off));
            exp_data.push_back(data);
            exp_size.push_back(size);
        end
        st_off += 8;
    endtask

    // One op into x5 followed by SD x5
    task run_op(input instr_t ins, input word_t exp_val);
        emit(ins);
        put_store(5'd5, SIZE_D, 1'b1, exp_val);
    endtask

    // LUI+ADDI pair with LFSR immediates
    task load_reg(input reg_idx_t rd, output word_t val);
        logic [19:0] hi;
        logic [11:0] lo;
        hi = rand_bits(20);
        lo = rand_bits(12);
        emit(u_type(hi, rd, OP_LUI));
        emit(i_type(lo, rd, F3_ADD, rd, OP_OP_IMM));
        val = {{32{hi[19]}}, hi, 12'b0} + {{52{lo[11]}}, lo};
    endtask

    // Branch over one store that retires only when the branch is not taken
    task branch_case(input funct3_t f3, input reg_idx_t rs1, input reg_idx_t rs2,
            input word_t x, input word_t y, input word_t a);
        emit(b_type(13'd8, rs2, rs1, f3));
        put_store(5'd1, SIZE_D, !branch_cond(f3, x, y), a);
    endtask

    task wait_store(input int idx);
        int n;
        n = 0;
        @(posedge clk_1hz);
        while (mem_we !== 1'b1 && n < WAIT_LIMIT) begin
            n++;
            @(posedge clk_1hz);
        end
        if (mem_we !== 1'b1) fail_run($sformatf("Timed out waiting for store %0d", idx));
    endtask

    initial begin
        word_t       a;
        word_t       b;
        word_t       imm;
        word_t       p;
        logic [11:0] lo12;
        logic [5:0]  sh;
        logic [19:0] u20;
        int          n;
        int          extra;

        lfsr     = LFSR_SEED;
        prog_len = 0;
        st_off   = 0;
        br_list  = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

        emit(i_type(12'h400, 5'd0, F3_ADD, 5'd3, OP_OP_IMM));   // x3 = store base
        load_reg(5'd1, a);
        load_reg(5'd2, b);
        emit(i_type(12'h0ff, 5'd0, 3'b000, 5'd0, OP_FENCE));    // FENCE
        emit(i_type(12'h000, 5'd0, 3'b001, 5'd0, OP_FENCE));    // FENCE.I

        // 64-bit register forms
        run_op(r_type(7'h00, 2, 1, F3_ADD, 5, OP_OP), a + b);
        run_op(r_type(F7_ALT, 2, 1, F3_ADD, 5, OP_OP), a - b);
        run_op(r_type(7'h00, 2, 1, F3_SLL, 5, OP_OP), a << b[5:0]);
        run_op(r_type(7'h00, 2, 1, F3_SLT, 5, OP_OP), word_t'($signed(a) < $signed(b)));
        run_op(r_type(7'h00, 2, 1, F3_SLTU, 5, OP_OP), word_t'(a < b));
        run_op(r_type(7'h00, 2, 1, F3_XOR, 5, OP_OP), a ^ b);
        run_op(r_type(7'h00, 2, 1, F3_SR, 5, OP_OP), a >> b[5:0]);
        run_op(r_type(F7_ALT, 2, 1, F3_SR, 5, OP_OP), word_t'($signed(a) >>> b[5:0]));
        run_op(r_type(7'h00, 2, 1, F3_OR, 5, OP_OP), a | b);
        run_op(r_type(7'h00, 2, 1, F3_AND, 5, OP_OP), a & b);

        // 64-bit immediate forms
        lo12 = rand_bits(12);
        sh   = rand_bits(6);
        imm  = {{52{lo12[11]}}, lo12};
        run_op(i_type(lo12, 1, F3_ADD, 5, OP_OP_IMM), a + imm);
        run_op(i_type(lo12, 1, F3_SLT, 5, OP_OP_IMM), word_t'($signed(a) < $signed(imm)));
        run_op(i_type(lo12, 1, F3_SLTU, 5, OP_OP_IMM), word_t'(a < imm));
        run_op(i_type(lo12, 1, F3_XOR, 5, OP_OP_IMM), a ^ imm);
        run_op(i_type(lo12, 1, F3_OR, 5, OP_OP_IMM), a | imm);
        run_op(i_type(lo12, 1, F3_AND, 5, OP_OP_IMM), a & imm);
        run_op(i_type({6'b000000, sh}, 1, F3_SLL, 5, OP_OP_IMM), a << sh);
        run_op(i_type({6'b000000, sh}, 1, F3_SR, 5, OP_OP_IMM), a >> sh);
        run_op(i_type({6'b010000, sh}, 1, F3_SR, 5, OP_OP_IMM), word_t'($signed(a) >>> sh));

        // Word forms sign-extended from bit 31
        run_op(r_type(7'h00, 2, 1, F3_ADD, 5, OP_OP_W), sext32(a[31:0] + b[31:0]));
        run_op(r_type(F7_ALT, 2, 1, F3_ADD, 5, OP_OP_W), sext32(a[31:0] - b[31:0]));
        run_op(r_type(7'h00, 2, 1, F3_SLL, 5, OP_OP_W), sext32(a[31:0] << b[4:0]));
        run_op(r_type(7'h00, 2, 1, F3_SR, 5, OP_OP_W), sext32(a[31:0] >> b[4:0]));
        run_op(r_type(F7_ALT, 2, 1, F3_SR, 5, OP_OP_W), sext32($signed(a[31:0]) >>> b[4:0]));
        run_op(r_type(7'h00, 0, 1, F3_SR, 5, OP_OP_W), sext32(a[31:0])); // srlw by zero
        run_op(i_type(lo12, 1, F3_ADD, 5, OP_OP_IMM_W), sext32(a[31:0] + imm[31:0]));
        run_op(i_type({7'h00, sh[4:0]}, 1, F3_SLL, 5, OP_OP_IMM_W), sext32(a[31:0] << sh[4:0]));
        run_op(i_type({7'h00, sh[4:0]}, 1, F3_SR, 5, OP_OP_IMM_W), sext32(a[31:0] >> sh[4:0]));
        run_op(i_type({F7_ALT, sh[4:0]}, 1, F3_SR, 5, OP_OP_IMM_W),
               sext32($signed(a[31:0]) >>> sh[4:0]));

        // Upper immediates
        u20 = rand_bits(20);
        run_op(u_type(u20, 5, OP_LUI), {{32{u20[19]}}, u20, 12'b0});
        p = RESET_PC + word_t'(prog_len * 4);
        run_op(u_type(u20, 5, OP_AUIPC), p + {{32{u20[19]}}, u20, 12'b0});

        // Writes to x0 are lost
        emit(i_type(lo12, 5'd1, F3_ADD, 5'd0, OP_OP_IMM));
        emit(u_type(u20, 5'd0, OP_LUI));
        put_store(5'd0, SIZE_D, 1'b1, '0);

        // JAL over one store with link pc+4
        p = RESET_PC + word_t'(prog_len * 4);
        emit(j_type(21'd8, 5'd5));
        put_store(5'd1, SIZE_D, 1'b0, '0);      // Skipped
        put_store(5'd5, SIZE_D, 1'b1, p + 4);

        // JALR to an odd sum lands on the even address below
        p = RESET_PC + word_t'(prog_len * 4);
        emit(i_type(12'(p + 13), 5'd0, F3_ADD, 5'd6, OP_OP_IMM));
        emit(i_type(12'h000, 5'd6, 3'b000, 5'd5, OP_JALR));
        put_store(5'd1, SIZE_D, 1'b0, '0);      // Skipped
        put_store(5'd5, SIZE_D, 1'b1, p + 8);

        // Six branches with swapped and equal operands
        for (int i = 0; i < 6; i++) begin
            branch_case(br_list[i], 5'd1, 5'd2, a, b, a);
            branch_case(br_list[i], 5'd2, 5'd1, b, a, a);
            branch_case(br_list[i], 5'd1, 5'd1, a, a, a);
        end

        // Narrow stores with upper data bits zero
        put_store(5'd1, SIZE_B, 1'b1, {56'b0, a[7:0]});
        put_store(5'd1, SIZE_H, 1'b1, {48'b0, a[15:0]});
        put_store(5'd1, SIZE_W, 1'b1, {32'b0, a[31:0]});

        // PC parked and no stores while in reset
        n = 0;
        @(negedge clk_1hz);
        while (reset_n !== 1'b1 && n < WAIT_LIMIT) begin
            check_word("imem_addr", imem_addr, RESET_PC);
            check_bit("mem_we", mem_we, 1'b0);
            n++;
            @(negedge clk_1hz);
        end
        if (reset_n !== 1'b1) fail_run("Reset was never released");
        check_word("imem_addr", imem_addr, RESET_PC);     // First cycle out of reset
        check_bit("mem_we", mem_we, 1'b0);

        // Stores in table order
        for (int i = 0; i < exp_addr.size(); i++) begin
            wait_store(i);
            check_word("mem_addr", mem_addr, exp_addr[i]);
            check_word("mem_data", mem_data, exp_data[i]);
            check_size("mem_size", mem_size, exp_size[i]);
        end

        // No stores beyond the table
        extra = 0;
        repeat (20) begin
            @(posedge clk_1hz);
            if (mem_we === 1'b1) extra++;
        end
        if (extra != 0) begin
            fail_run($sformatf("%0d unexpected stores after the last expected one", extra));
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
logic/rv_isa_pkg.sv
logic/rv_core_pkg.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/int_alu.sv
logic/flow_unit.sv
logic/commit_unit.sv
logic/rv_core.sv
bench/tb_clock_gen.sv
bench/rv_core_tb.sv
